// File: aexmFrontEnd.f
design/aexmPkg.sv
design/instFetch.sv
design/instBuffer.sv
design/regFile.sv
design/operandStage.sv
design/aexmFrontEnd.sv
bench/tbInstMem.sv
bench/tbFrontEnd.sv

// File: bench/tbFrontEnd.sv
`timescale 1ns/1ns

module tbFrontEnd;

  typedef struct packed {
    aexmPkg::instT inst;
    aexmPkg::wordT opA;
    aexmPkg::wordT opB;
    aexmPkg::wordT opD;
    aexmPkg::regAddrT rd;
  } recT;

  // Output records for 27 program words plus the injected word
  localparam int totalRecs = 28;

  logic gclk;
  logic grst;
  logic run;
  logic msrIe;
  logic sysInt;
  logic imemAck;
  aexmPkg::instT imemData;
  logic imemReq;
  aexmPkg::pcT imemAddr;
  logic rfWe;
  aexmPkg::regAddrT rfWaddr;
  aexmPkg::wordT rfWdata;
  logic outAck;
  logic outReq;
  aexmPkg::instT outInst;
  aexmPkg::wordT outOpA;
  aexmPkg::wordT outOpB;
  aexmPkg::wordT outOpD;
  aexmPkg::regAddrT outRd;
  logic cpuInterrupt;

  integer seed = 72;
  aexmPkg::wordT preload [0:31];
  logic intArmed = 1'b0;
  logic allDone = 1'b0;
  int recCount = 0;
  int progIdx = 0;
  int intCount = 0;
  int replayCount = 0;
  logic prevReq = 1'b0;
  logic anyFetch = 1'b0;
  aexmPkg::pcT lastAddr = '0;

  aexmFrontEnd u_aexmFrontEnd (
    .gclk (gclk), .grst (grst), .run (run), .msrIe (msrIe), .sysInt (sysInt),
    .imemAck (imemAck), .imemData (imemData), .imemReq (imemReq), .imemAddr (imemAddr),
    .rfWe (rfWe), .rfWaddr (rfWaddr), .rfWdata (rfWdata),
    .outAck (outAck), .outReq (outReq), .outInst (outInst),
    .outOpA (outOpA), .outOpB (outOpB), .outOpD (outOpD), .outRd (outRd),
    .cpuInterrupt (cpuInterrupt)
  );

  tbInstMem u_tbInstMem (
    .gclk (gclk), .imemReq (imemReq), .imemAddr (imemAddr),
    .imemAck (imemAck), .imemData (imemData)
  );

  initial begin
    gclk = 1'b0;
    forever #50 gclk = ~gclk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkInst(input string name, input aexmPkg::instT expVal,
                           input aexmPkg::instT actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("ERR %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkWord(input string name, input aexmPkg::wordT expVal,
                           input aexmPkg::wordT actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("ERR %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkReg(input string name, input aexmPkg::regAddrT expVal,
                          input aexmPkg::regAddrT actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("ERR %s expected %0d actual %0d", name, expVal, actVal));
    end
  endtask

  task automatic checkAddr(input string name, input aexmPkg::pcT expVal, input aexmPkg::pcT actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("ERR %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("ERR %s expected %b actual %b", name, expVal, actVal));
    end
  endtask

  // Preload pattern distinct per register
  function automatic aexmPkg::wordT preloadValue(input int idx);
    aexmPkg::regAddrT a;
    a = idx[4:0];
    return {8'hA5, 3'b000, a, 8'h3C, 3'b000, ~a};
  endfunction

  // r0 always reads zero
  function automatic aexmPkg::wordT regValue(input aexmPkg::regAddrT a);
    if (a == 5'd0) return '0;
    else return preload[a];
  endfunction

  // Words after which injection must not land
  function automatic logic blocksInterrupt(input aexmPkg::instT w);
    aexmPkg::opcodeT opc;
    opc = w[31:26];
    return (opc == aexmPkg::opImm) || (opc == aexmPkg::opRtd) ||
           (opc == aexmPkg::opBru) || (opc == aexmPkg::opBrui) ||
           (opc == aexmPkg::opBcc) || (opc == aexmPkg::opBcci);
  endfunction

  // Expected record for a word and its predecessor
  function automatic recT refRecord(input aexmPkg::instT word, input aexmPkg::instT prev);
    recT rec;
    aexmPkg::opcodeT opc;
    aexmPkg::immT low;
    aexmPkg::wordT imm;
    opc = word[31:26];
    low = word[15:0];
    // IMM prefix supplies the upper half
    if (prev[31:26] == aexmPkg::opImm) imm = {prev[15:0], low};
    else imm = {{16{low[15]}}, low};
    rec.inst = word;
    rec.opA = regValue(word[20:16]);
    // Immediate forms have opcode bit 3 set
    if (opc[3]) rec.opB = imm;
    else rec.opB = regValue(word[15:11]);
    rec.opD = regValue(word[25:21]);
    rec.rd = word[25:21];
    return rec;
  endfunction

  task automatic waitRecords(input int target);
    int cycles;
    cycles = 0;
    while (recCount < target && cycles < 500) begin
      @(negedge gclk);
      cycles++;
    end
    if (recCount < target) abortRun("timeout waiting for output records");
  endtask

  // Fetch addresses step by 4 with one repeat for the replay
  always @(negedge gclk) begin : addrMonitor
    aexmPkg::pcT expAddr;
    if (imemReq === 1'b1 && !prevReq) begin
      if (!anyFetch) begin
        expAddr = aexmPkg::resetPc;
      end else if (imemAddr == lastAddr && intArmed && replayCount == 0) begin
        expAddr = lastAddr;
        replayCount++;
      end else begin
        expAddr = lastAddr + 32'd4;
      end
      checkAddr("fetch address", expAddr, imemAddr);
      lastAddr = imemAddr;
      anyFetch = 1'b1;
    end
    prevReq = (imemReq === 1'b1);
  end

  // Output consumer and record compare
  initial begin : consumer
    int cycles;
    int ackDelay;
    logic injected;
    logic intFlag;
    logic prevFlag;
    recT expRec;
    aexmPkg::instT prevWord;
    aexmPkg::instT olderWord;
    outAck = 1'b0;
    prevWord = '0;
    olderWord = '0;
    prevFlag = 1'b0;
    while (recCount < totalRecs) begin
      cycles = 0;
      do begin
        @(negedge gclk);
        cycles++;
      end while (outReq !== 1'b1 && cycles < 300);
      if (outReq !== 1'b1) abortRun("timeout waiting for an output request");
      ackDelay = $unsigned($random(seed)) % 5;
      repeat (ackDelay) @(negedge gclk);
      intFlag = cpuInterrupt;
      injected = (outInst === aexmPkg::intInst) && intArmed && (intCount == 0);
      // Flag is high over the record just before the injected one
      checkBit($sformatf("cpuInterrupt before rec%0d", recCount), injected, prevFlag);
      // Injected word takes no program slot
      if (injected) begin
        if (blocksInterrupt(prevWord)) begin
          abortRun($sformatf("interrupt word issued after guarded word %h", prevWord));
        end
        if (olderWord[31:26] == aexmPkg::opImm) begin
          abortRun($sformatf("interrupt word issued after IMM-prefixed word %h", prevWord));
        end
        expRec = refRecord(aexmPkg::intInst, prevWord);
        intCount++;
      end else begin
        expRec = refRecord(u_tbInstMem.mem[progIdx], prevWord);
        progIdx++;
      end
      checkInst($sformatf("rec%0d inst", recCount), expRec.inst, outInst);
      checkWord($sformatf("rec%0d opA", recCount), expRec.opA, outOpA);
      checkWord($sformatf("rec%0d opB", recCount), expRec.opB, outOpB);
      checkWord($sformatf("rec%0d opD", recCount), expRec.opD, outOpD);
      checkReg($sformatf("rec%0d rd", recCount), expRec.rd, outRd);
      olderWord = prevWord;
      prevWord = outInst;
      prevFlag = intFlag;
      recCount++;
      outAck = 1'b1;
      cycles = 0;
      do begin
        @(negedge gclk);
        cycles++;
      end while (outReq !== 1'b0 && cycles < 20);
      if (outReq !== 1'b0) abortRun("output request stayed high after acknowledge");
      outAck = 1'b0;
    end
    checkBit("cpuInterrupt after last record", 1'b0, prevFlag);
    allDone = 1'b1;
  end

  initial begin : mainSeq
    int cycles;
    grst = 1'b1;
    run = 1'b0;
    msrIe = 1'b0;
    sysInt = 1'b0;
    rfWe = 1'b0;
    rfWaddr = '0;
    rfWdata = '0;
    for (int i = 0; i < 32; i++) preload[i] = preloadValue(i);
    // Three reset cycles counted on rising edges
    repeat (3) @(posedge gclk);
    @(negedge gclk);
    grst = 1'b0;
    // r0 written too and must stay zero
    for (int i = 0; i < 32; i++) begin
      @(negedge gclk);
      rfWe = 1'b1;
      rfWaddr = i[4:0];
      rfWdata = preload[i];
    end
    @(negedge gclk);
    rfWe = 1'b0;
    run = 1'b1;
    // Masked pulse with no injection expected
    waitRecords(6);
    sysInt = 1'b1;
    repeat (4) @(negedge gclk);
    sysInt = 1'b0;
    // Enabled pulse over a run of guarded words
    waitRecords(12);
    msrIe = 1'b1;
    intArmed = 1'b1;
    repeat (2) @(negedge gclk);
    sysInt = 1'b1;
    repeat (4) @(negedge gclk);
    sysInt = 1'b0;
    cycles = 0;
    while (!allDone && cycles < 2000) begin
      @(negedge gclk);
      cycles++;
    end
    if (!allDone) begin
      abortRun("timeout waiting for the consumer to finish");
    end else if (intCount != 1) begin
      abortRun($sformatf("ERR interrupt count expected 1 actual %0d", intCount));
    end else if (replayCount != 1) begin
      abortRun($sformatf("ERR fetch replay count expected 1 actual %0d", replayCount));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: bench/tbInstMem.sv
`timescale 1ns/1ns

module tbInstMem (
  input  logic          gclk,
  input  logic          imemReq,
  input  aexmPkg::pcT   imemAddr,
  output logic          imemAck,
  output aexmPkg::instT imemData
);

  // Program storage, 64 words
  aexmPkg::instT mem [0:63];
  integer seed = 72;
  int delayLeft = 0;
  logic ackOut = 1'b0;
  aexmPkg::instT dataOut = '0;

  assign imemAck = ackOut;
  assign imemData = dataOut;

  // Register form encoding
  function automatic aexmPkg::instT rType(input aexmPkg::opcodeT opc, input aexmPkg::regAddrT rd,
                                          input aexmPkg::regAddrT ra, input aexmPkg::regAddrT rb);
    return {opc, rd, ra, rb, 11'd0};
  endfunction

  // Immediate form encoding
  function automatic aexmPkg::instT iType(input aexmPkg::opcodeT opc, input aexmPkg::regAddrT rd,
                                          input aexmPkg::regAddrT ra, input aexmPkg::immT imm);
    return {opc, rd, ra, imm};
  endfunction

  initial begin : loadProgram
    logic [5:0] fill;
    for (int i = 0; i < 64; i++) begin
      fill = i[5:0];
      // Plain adds, register fields spread over the index
      mem[i] = {6'o00, fill[4:0], fill[5:1], fill[4:0] ^ 5'h15, 5'd0, fill};
    end
    mem[0] = rType(6'o00, 3, 1, 2);
    mem[1] = iType(6'o10, 4, 5, 16'hfff0);
    // IMM pair
    mem[2] = iType(6'o54, 0, 0, 16'h1234);
    mem[3] = iType(6'o10, 6, 7, 16'h8001);
    mem[4] = rType(6'o40, 8, 0, 9);
    mem[5] = iType(6'o56, 0, 0, 16'h0040);
    mem[6] = rType(6'o00, 10, 11, 12);
    mem[7] = iType(6'o72, 13, 14, 16'h0008);
    mem[8] = rType(6'o66, 15, 16, 0);
    mem[9] = iType(6'o57, 2, 17, 16'h7ffc);
    mem[10] = iType(6'o50, 18, 19, 16'h00ff);
    mem[11] = iType(6'o54, 0, 0, 16'hdead);
    mem[12] = iType(6'o76, 20, 21, 16'hbeef);
    // Run of words that block injection
    mem[13] = rType(6'o46, 0, 22, 23);
    mem[14] = iType(6'o55, 15, 0, 16'h0008);
    mem[15] = rType(6'o47, 1, 27, 28);
    mem[16] = iType(6'o54, 0, 0, 16'h0001);
    mem[17] = iType(6'o54, 0, 0, 16'h0002);
    mem[18] = iType(6'o10, 31, 1, 16'h0003);
    mem[19] = rType(6'o62, 5, 6, 7);
    mem[20] = iType(6'o10, 9, 0, 16'h8000);
  end

  // Four-phase responder with random ack delay
  always @(negedge gclk) begin
    if (imemReq === 1'b1 && !ackOut) begin
      if (delayLeft == 0) begin
        dataOut <= mem[imemAddr[7:2]];
        ackOut <= 1'b1;
        delayLeft <= $unsigned($random(seed)) % 4;
      end else begin
        delayLeft <= delayLeft - 1;
      end
    end else if (imemReq === 1'b0 && ackOut) begin
      ackOut <= 1'b0;
    end
  end

endmodule

// File: design/aexmFrontEnd.sv
`timescale 1ns/1ns

module aexmFrontEnd (
  input  logic             gclk,
  input  logic             grst,
  input  logic             run,
  input  logic             msrIe,
  input  logic             sysInt,
  input  logic             imemAck,
  input  aexmPkg::instT    imemData,
  output logic             imemReq,
  output aexmPkg::pcT      imemAddr,
  input  logic             rfWe,
  input  aexmPkg::regAddrT rfWaddr,
  input  aexmPkg::wordT    rfWdata,
  input  logic             outAck,
  output logic             outReq,
  output aexmPkg::instT    outInst,
  output aexmPkg::wordT    outOpA,
  output aexmPkg::wordT    outOpB,
  output aexmPkg::wordT    outOpD,
  output aexmPkg::regAddrT outRd,
  output logic             cpuInterrupt
);

  // Fetch to decode
  aexmPkg::instT fetchWord;
  logic decodeEn;
  logic replay;
  logic outBusy;

  // Decode to register file and output stage
  aexmPkg::regAddrT rdAddr;
  aexmPkg::regAddrT raAddr;
  aexmPkg::regAddrT rbAddr;
  aexmPkg::instT issueInst;
  aexmPkg::wordT issueImm;

  // Register file read data
  aexmPkg::wordT raData;
  aexmPkg::wordT rbData;
  aexmPkg::wordT rdData;

  instFetch u_instFetch (
    .gclk      (gclk),
    .grst      (grst),
    .run       (run),
    .outBusy   (outBusy),
    .replay    (replay),
    .imemAck   (imemAck),
    .imemData  (imemData),
    .imemReq   (imemReq),
    .imemAddr  (imemAddr),
    .fetchWord (fetchWord),
    .decodeEn  (decodeEn)
  );

  instBuffer u_instBuffer (
    .gclk         (gclk),
    .grst         (grst),
    .decodeEn     (decodeEn),
    .fetchWord    (fetchWord),
    .msrIe        (msrIe),
    .sysInt       (sysInt),
    .rdAddr       (rdAddr),
    .raAddr       (raAddr),
    .rbAddr       (rbAddr),
    .issueInst    (issueInst),
    .issueImm     (issueImm),
    .replay       (replay),
    .cpuInterrupt (cpuInterrupt)
  );

  // Write port is driven from outside the front end
  regFile u_regFile (
    .gclk   (gclk),
    .raAddr (raAddr),
    .rbAddr (rbAddr),
    .rdAddr (rdAddr),
    .we     (rfWe),
    .waddr  (rfWaddr),
    .wdata  (rfWdata),
    .raData (raData),
    .rbData (rbData),
    .rdData (rdData)
  );

  operandStage u_operandStage (
    .gclk      (gclk),
    .grst      (grst),
    .decodeEn  (decodeEn),
    .issueInst (issueInst),
    .issueImm  (issueImm),
    .raData    (raData),
    .rbData    (rbData),
    .rdData    (rdData),
    .outAck    (outAck),
    .outReq    (outReq),
    .outBusy   (outBusy),
    .outInst   (outInst),
    .outOpA    (outOpA),
    .outOpB    (outOpB),
    .outOpD    (outOpD),
    .outRd     (outRd)
  );

endmodule

// File: design/operandStage.sv
`timescale 1ns/1ns

module operandStage (
  input  logic             gclk,
  input  logic             grst,
  input  logic             decodeEn,
  input  aexmPkg::instT    issueInst,
  input  aexmPkg::wordT    issueImm,
  input  aexmPkg::wordT    raData,
  input  aexmPkg::wordT    rbData,
  input  aexmPkg::wordT    rdData,
  input  logic             outAck,
  output logic             outReq,
  output logic             outBusy,
  output aexmPkg::instT    outInst,
  output aexmPkg::wordT    outOpA,
  output aexmPkg::wordT    outOpB,
  output aexmPkg::wordT    outOpD,
  output aexmPkg::regAddrT outRd
);

  aexmPkg::outStateT state;
  aexmPkg::opcodeT issueOpc;
  logic immForm;

  // Type B forms have opcode bit 3 set
  assign issueOpc = issueInst[31:26];
  assign immForm = issueOpc[3];

  // Fetch holds its word while a record is pending
  assign outBusy = (state != aexmPkg::osEmpty);

  // Record capture
  always_ff @(posedge gclk) begin
    if (decodeEn) begin
      outInst <= issueInst;
      outOpA <= raData;
      outOpB <= immForm ? issueImm : rbData;
      outOpD <= rdData;
      outRd <= issueInst[25:21];
    end
  end

  // Output handshake FSM
  always_ff @(posedge gclk) begin
    if (grst) begin
      state <= aexmPkg::osEmpty;
      outReq <= 1'b0;
    end else begin
      case (state)
        aexmPkg::osEmpty: begin
          // Req follows the capture by one cycle
          if (decodeEn) begin
            outReq <= 1'b1;
            state <= aexmPkg::osReq;
          end
        end
        aexmPkg::osReq: begin
          if (outAck) begin
            outReq <= 1'b0;
            state <= aexmPkg::osDrop;
          end
        end
        aexmPkg::osDrop: begin
          // Wait for the consumer to release ack
          if (!outAck) begin
            state <= aexmPkg::osEmpty;
          end
        end
        default: begin
          outReq <= 1'b0;
          state <= aexmPkg::osEmpty;
        end
      endcase
    end
  end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic             gclk,
  input  aexmPkg::regAddrT raAddr,
  input  aexmPkg::regAddrT rbAddr,
  input  aexmPkg::regAddrT rdAddr,
  input  logic             we,
  input  aexmPkg::regAddrT waddr,
  input  aexmPkg::wordT    wdata,
  output aexmPkg::wordT    raData,
  output aexmPkg::wordT    rbData,
  output aexmPkg::wordT    rdData
);

  // Register storage
  aexmPkg::wordT regs [0:31];

  // Write port
  // r0 is never written
  always_ff @(posedge gclk) begin
    if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Operand A read
  always_comb begin
    if (raAddr == 5'd0) begin
      raData = '0;
    end else begin
      raData = regs[raAddr];
    end
  end

  // Operand B read
  always_comb begin
    if (rbAddr == 5'd0) begin
      rbData = '0;
    end else begin
      rbData = regs[rbAddr];
    end
  end

  // Store data read
  always_comb begin
    if (rdAddr == 5'd0) begin
      rdData = '0;
    end else begin
      rdData = regs[rdAddr];
    end
  end

endmodule

// File: design/instBuffer.sv
`timescale 1ns/1ns

module instBuffer (
  input  logic              gclk,
  input  logic              grst,
  input  logic              decodeEn,
  input  aexmPkg::instT     fetchWord,
  input  logic              msrIe,
  input  logic              sysInt,
  output aexmPkg::regAddrT  rdAddr,
  output aexmPkg::regAddrT  raAddr,
  output aexmPkg::regAddrT  rbAddr,
  output aexmPkg::instT     issueInst,
  output aexmPkg::wordT     issueImm,
  output logic              replay,
  output logic              cpuInterrupt
);

  // Interrupt synchronizer and pending flag
  logic [1:0] intSync;
  logic intPend;
  logic intShot;
  logic intIssue;
  logic doInterrupt;

  // Opcode classes of the fetched word
  aexmPkg::opcodeT fetchOpc;
  logic isImm;
  logic isRtd;
  logic isBranch;

  // State of the previously decoded word
  logic prevImm;
  aexmPkg::immT immHigh;

  // Word actually issued this slot
  aexmPkg::instT selWord;
  aexmPkg::immT selLow;

  assign fetchOpc = fetchWord[31:26];
  assign isImm = (fetchOpc == aexmPkg::opImm);
  assign isRtd = (fetchOpc == aexmPkg::opRtd);
  assign isBranch = (fetchOpc == aexmPkg::opBru) || (fetchOpc == aexmPkg::opBrui) ||
                    (fetchOpc == aexmPkg::opBcc) || (fetchOpc == aexmPkg::opBcci);

  // Rising edge of the debounced line
  assign intShot = intSync[0] & ~intSync[1];

  // Injection slot consumed
  assign intIssue = decodeEn & cpuInterrupt;
  // Displaced word must be fetched again
  assign replay = intIssue;

  // Delay slot guard
  // No injection behind IMM, RTD or a branch
  assign doInterrupt = intPend && !cpuInterrupt && !prevImm &&
                       !(isImm || isRtd || isBranch);

  // Interrupt latch
  // Sampled only with interrupts enabled
  always_ff @(posedge gclk) begin
    if (grst) begin
      intSync <= 2'b00;
      intPend <= 1'b0;
    end else begin
      if (msrIe) begin
        intSync <= {intSync[0], sysInt};
      end
      if (intIssue) begin
        intPend <= 1'b0;
      end else begin
        intPend <= (intPend | intShot) & msrIe;
      end
    end
  end

  // Injected word takes the slot after acceptance
  assign selWord = cpuInterrupt ? aexmPkg::intInst : fetchWord;
  assign selLow = selWord[15:0];
  assign issueInst = selWord;

  // Immediate merge after IMM, else sign extension
  assign issueImm = prevImm ? {immHigh, selLow} : {{16{selLow[15]}}, selLow};

  // Register file read addresses
  assign rdAddr = selWord[25:21];
  assign raAddr = selWord[20:16];
  assign rbAddr = selWord[15:11];

  // Decode history and acceptance
  always_ff @(posedge gclk) begin
    if (grst) begin
      cpuInterrupt <= 1'b0;
      prevImm <= 1'b0;
    end else if (decodeEn) begin
      cpuInterrupt <= doInterrupt;
      prevImm <= (selWord[31:26] == aexmPkg::opImm);
    end
  end

  // Upper half for a following word
  always_ff @(posedge gclk) begin
    if (decodeEn) begin
      immHigh <= selLow;
    end
  end

endmodule

// File: design/instFetch.sv
`timescale 1ns/1ns

module instFetch (
  input  logic          gclk,
  input  logic          grst,
  input  logic          run,
  input  logic          outBusy,
  input  logic          replay,
  input  logic          imemAck,
  input  aexmPkg::instT imemData,
  output logic          imemReq,
  output aexmPkg::pcT   imemAddr,
  output aexmPkg::instT fetchWord,
  output logic          decodeEn
);

  aexmPkg::fetchStateT state;
  aexmPkg::pcT pc;
  aexmPkg::instT holdWord;

  // Address stays stable while req is high
  assign imemAddr = pc;
  // Held word feeds decode until the next capture
  assign fetchWord = holdWord;

  // Requester FSM
  always_ff @(posedge gclk) begin
    if (grst) begin
      state <= aexmPkg::fsIdle;
      imemReq <= 1'b0;
      decodeEn <= 1'b0;
    end else begin
      // Decode enable is a single cycle pulse
      decodeEn <= 1'b0;
      case (state)
        aexmPkg::fsIdle: begin
          // Start only with the output stage free
          if (run && !outBusy && !imemAck) begin
            imemReq <= 1'b1;
            state <= aexmPkg::fsReq;
          end
        end
        aexmPkg::fsReq: begin
          if (imemAck) begin
            // Data valid with ack, drop req now
            imemReq <= 1'b0;
            if (outBusy) begin
              state <= aexmPkg::fsWait;
            end else begin
              decodeEn <= 1'b1;
              state <= aexmPkg::fsRelease;
            end
          end
        end
        aexmPkg::fsWait: begin
          // Word held until the output record is taken
          if (!outBusy) begin
            decodeEn <= 1'b1;
            state <= aexmPkg::fsRelease;
          end
        end
        aexmPkg::fsRelease: begin
          // New req only after ack has fallen
          if (!imemAck) begin
            if (run) begin
              imemReq <= 1'b1;
              state <= aexmPkg::fsReq;
            end else begin
              state <= aexmPkg::fsIdle;
            end
          end
        end
        default: state <= aexmPkg::fsIdle;
      endcase
    end
  end

  // Program counter
  // Replay keeps the address of a displaced word
  always_ff @(posedge gclk) begin
    if (grst) begin
      pc <= aexmPkg::resetPc;
    end else if (decodeEn && !replay) begin
      pc <= pc + 32'd4;
    end
  end

  // Fetched word capture
  always_ff @(posedge gclk) begin
    if (state == aexmPkg::fsReq && imemAck) begin
      holdWord <= imemData;
    end
  end

endmodule

// File: design/aexmPkg.sv
package aexmPkg;

  // Word and field widths
  typedef logic [31:0] instT;
  typedef logic [31:0] wordT;
  typedef logic [31:0] pcT;
  typedef logic [4:0] regAddrT;
  typedef logic [5:0] opcodeT;
  typedef logic [15:0] immT;

  // Major opcodes used by decode
  // IMM prefix carries the upper immediate half
  localparam opcodeT opImm = 6'o54;
  // Return from subroutine
  localparam opcodeT opRtd = 6'o55;
  // Unconditional branch, register and immediate forms
  localparam opcodeT opBru = 6'o46;
  localparam opcodeT opBrui = 6'o56;
  // Conditional branch, register and immediate forms
  localparam opcodeT opBcc = 6'o47;
  localparam opcodeT opBcci = 6'o57;

  // Injected interrupt word
  // brali r14 with target 0x10
  localparam instT intInst = {6'o56, 5'd14, 5'h0c, 16'h0010};

  // First fetch address after reset
  localparam pcT resetPc = 32'h0000_0000;

  // Instruction fetch requester
  typedef enum logic [1:0] {
    fsIdle,
    fsReq,
    fsRelease,
    fsWait
  } fetchStateT;

  // Operand output handshake
  typedef enum logic [1:0] {
    osEmpty,
    osReq,
    osDrop
  } outStateT;

endpackage
